// ==== hdl/div_pkg.sv ====
package div_pkg;

	// ######################################################################
	// data widths
	// ######################################################################

	typedef logic [31:0] word_t;	// operands, quotient, remainder
	typedef logic [34:0] rem_t;	// partial remainder, 3 guard bits for 3x divisor

	// ######################################################################
	// sequencer
	// ######################################################################

	// init is never held in the state register
	// it is the idle state seen with a request at the queue head
	typedef enum logic [2:0] {
		st_idle,
		st_init,
		st_step,
		st_last,
		st_done
	} seq_state_t;

	localparam int DIV_STEPS = 16;	// radix-4 steps for 32 bits

endpackage

// ==== hdl/div_op_if.sv ====
`timescale 1ns/10ps

// head of the request queue as seen by the divide side
interface div_op_if
	import div_pkg::*;
();
	logic empty;	// no request pending
	logic pop;	// consume head this cycle
	word_t dividend;
	word_t divisor;
	logic unsign;	// treat both operands as unsigned

	modport queue_mp (
		output empty,
		output dividend,
		output divisor,
		output unsign,
		input pop
	);

	modport seq_mp (
		input empty,
		input dividend,
		input divisor,
		input unsign,
		output pop
	);
endinterface

// ==== hdl/csa35.sv ====
`timescale 1ns/10ps

// 3:2 compressor over the full remainder width
// sum and carry stay separate, carry weight is one bit above sum
module csa35
	import div_pkg::*;
(
	input rem_t ain,
	input rem_t bin,
	input rem_t cin,
	output rem_t sout,
	output rem_t cout
);

	// bitwise full adders, no carry ripple
	assign sout = ain ^ bin ^ cin;

	// majority of the three inputs per bit
	// caller shifts this left by one before the final add
	assign cout = (ain & bin) |
		(ain & cin) |
		(bin & cin);

endmodule

// ==== hdl/long_div.sv ====
`timescale 1ns/10ps

// radix-4 restoring divider, 16 advance steps plus one correction step
// dvd starts as the dividend and fills with quotient bits from below
module long_div
	import div_pkg::*;
(
	input logic clk,
	input logic d_init,
	input logic e_advance,
	input logic e_last,
	input word_t dividend,
	input word_t divisor,
	input logic unsign,
	output word_t quot,
	output word_t remd
);

	logic sign_divisor;
	logic sign_dividend;
	word_t dvs;	// divisor as loaded
	word_t dvd;	// dividend bits, then quotient bits
	logic sign_dvs;
	logic sign_dvd;
	logic sign_quot;
	logic sub;	// subtract divisor multiples, else add
	rem_t rem;	// partial remainder, sign kept equal to dividend
	rem_t rem_sh;
	rem_t dvs_ivt;
	rem_t dvs_ivt2;
	rem_t sum3;
	rem_t carry3;
	rem_t trial1;
	rem_t trial2;
	rem_t trial3;
	rem_t rem_nxt;
	rem_t rem_fix;
	logic ok1;
	logic ok2;
	logic ok3;
	logic fix;
	logic [1:0] digit;
	logic [1:0] qbits;

	assign sign_divisor = divisor[31] & ~unsign;
	assign sign_dividend = dividend[31] & ~unsign;

	// ######################################################################
	// operand registers
	// ######################################################################

	always_ff @(posedge clk) begin
		if (d_init) begin
			dvs <= divisor;
			sign_dvs <= sign_divisor;
			sign_dvd <= sign_dividend;
			sign_quot <= sign_dividend ^ sign_divisor;	// from incoming operands
		end
	end

	// ######################################################################
	// trial subtraction, divisor times 1, 2 and 3
	// ######################################################################

	// same signs move the remainder down, different signs move it up
	assign sub = ~sign_quot;

	assign rem_sh = {rem[32:0], dvd[31:30]};	// next two dividend bits
	assign dvs_ivt = {35{sub}} ^ {{3{sign_dvs}}, dvs};	// +/-D, less the +1 for negation
	assign dvs_ivt2 = {dvs_ivt[33:0], sub};	// same for 2D

	assign trial1 = rem_sh + dvs_ivt + {34'b0, sub};
	assign trial2 = rem_sh + dvs_ivt2 + {34'b0, sub};

	csa35 u_csa (
		.ain  (rem_sh),
		.bin  (dvs_ivt),
		.cin  (dvs_ivt2),
		.sout (sum3),
		.cout (carry3)
	);

	// carry shifted up, the two negation ones go in at bit 0
	assign trial3 = sum3 + {carry3[33:0], sub} + {34'b0, sub};

	// a trial is usable while its sign still matches the dividend
	assign ok1 = (trial1[34] == sign_dvd);
	assign ok2 = (trial2[34] == sign_dvd);
	assign ok3 = (trial3[34] == sign_dvd);

	always_comb begin
		if (ok3) begin
			digit = 2'd3;
			rem_nxt = trial3;
		end else if (ok2) begin
			digit = 2'd2;
			rem_nxt = trial2;
		end else if (ok1) begin
			digit = 2'd1;
			rem_nxt = trial1;
		end else begin
			digit = 2'd0;
			rem_nxt = rem_sh;	// restore
		end
	end

	assign qbits = digit ^ {2{sign_quot}};	// ones' complement when negative

	// ######################################################################
	// last step
	// ######################################################################

	// a negative dividend ends with remainder in [-|D|, -1]
	// -|D| means an exact multiple, so fold it into the quotient
	assign rem_fix = rem + dvs_ivt + {34'b0, sub};
	assign fix = sign_dvd & (rem_fix == '0);

	always_ff @(posedge clk) begin
		if (d_init)
			dvd <= dividend;
		else if (e_advance)
			dvd <= {dvd[29:0], qbits};
		else if (e_last)
			dvd <= dvd + {31'b0, sign_quot ^ fix};	// +1 completes two's complement
	end

	always_ff @(posedge clk) begin
		if (d_init)
			rem <= {35{sign_dividend}};	// sign extension of the dividend
		else if (e_advance)
			rem <= rem_nxt;
		else if (e_last && fix)
			rem <= '0;
	end

	assign quot = dvd;
	assign remd = rem[31:0];

	a_init_not_advance: assert property (@(posedge clk) d_init |-> !e_advance)
		else $error("long_div: e_advance together with d_init");

endmodule

// ==== hdl/div_request_queue.sv ====
`timescale 1ns/10ps

// circular buffer of pending divide requests
module div_request_queue
	import div_pkg::*;
#(
	parameter int QUEUE_DEPTH = 4	// power of two, 2 or more
) (
	input logic clk,
	input logic rst,
	input logic push,
	input word_t dividend,
	input word_t divisor,
	input logic unsign,
	output logic full,
	div_op_if.queue_mp op
);

	localparam int PTR_W = $clog2(QUEUE_DEPTH);
	localparam int CNT_W = $clog2(QUEUE_DEPTH) + 1;

	word_t dvd_mem [QUEUE_DEPTH];
	word_t dvs_mem [QUEUE_DEPTH];
	logic [QUEUE_DEPTH-1:0] uns_mem;
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;
	logic do_push;
	logic do_pop;

	assign do_push = push & ~full;	// push into a full queue is dropped
	assign do_pop = op.pop & ~op.empty;

	// storage
	always_ff @(posedge clk) begin
		if (do_push) begin
			dvd_mem[wr_ptr] <= dividend;
			dvs_mem[wr_ptr] <= divisor;
			uns_mem[wr_ptr] <= unsign;
		end
	end

	// pointers wrap on their own, depth is a power of two
	always_ff @(posedge clk) begin
		if (rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (do_push)
				wr_ptr <= wr_ptr + 1'b1;
			if (do_pop)
				rd_ptr <= rd_ptr + 1'b1;
			case ({do_push, do_pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;	// none, or both at once
			endcase
		end
	end

	assign full = (count == CNT_W'(QUEUE_DEPTH));
	assign op.empty = (count == '0);

	// head entry, visible the cycle after it is written
	assign op.dividend = dvd_mem[rd_ptr];
	assign op.divisor = dvs_mem[rd_ptr];
	assign op.unsign = uns_mem[rd_ptr];

	a_no_pop_empty: assert property (@(posedge clk) disable iff (rst) op.pop |-> !op.empty)
		else $error("div_request_queue: pop while empty");

	a_count_range: assert property (@(posedge clk) disable iff (rst)
		count <= CNT_W'(QUEUE_DEPTH))
		else $error("div_request_queue: count above depth");

endmodule

// ==== hdl/div_sequencer.sv ====
`timescale 1ns/10ps

// steps one request through the datapath, 19 cycles from pop to done
module div_sequencer
	import div_pkg::*;
(
	input logic clk,
	input logic rst,
	div_op_if.seq_mp op,
	output logic d_init,
	output logic e_advance,
	output logic e_last,
	output logic busy,
	output logic done
);

	localparam int CNT_W = $clog2(DIV_STEPS);

	seq_state_t state_q;	// idle, step, last or done
	seq_state_t phase;	// state_q with init resolved
	logic [CNT_W-1:0] step_cnt;

	// idle with a request waiting is the init cycle
	// so a new request can start right after done
	always_comb begin
		phase = state_q;
		if (state_q == st_idle && !op.empty)
			phase = st_init;
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state_q <= st_idle;
			step_cnt <= '0;
		end else begin
			case (phase)
				st_init: begin
					state_q <= st_step;
					step_cnt <= '0;
				end
				st_step: begin
					step_cnt <= step_cnt + 1'b1;
					if (step_cnt == CNT_W'(DIV_STEPS - 1))
						state_q <= st_last;
				end
				st_last: state_q <= st_done;
				st_done: state_q <= st_idle;
				default: state_q <= st_idle;
			endcase
		end
	end

	// ######################################################################
	// strobes
	// ######################################################################

	assign op.pop = (phase == st_init);	// head leaves as the datapath loads it
	assign d_init = (phase == st_init);
	assign e_advance = (phase == st_step);
	assign e_last = (phase == st_last);
	assign done = (phase == st_done);
	assign busy = (phase != st_idle);

	a_strobes_onehot: assert property (@(posedge clk) disable iff (rst)
		$onehot0({d_init, e_advance, e_last}))
		else $error("div_sequencer: datapath strobes overlap");

	a_step_count: assert property (@(posedge clk) disable iff (rst)
		d_init |=> e_advance [*DIV_STEPS] ##1 e_last)
		else $error("div_sequencer: e_last not after DIV_STEPS advance cycles");

endmodule

// ==== hdl/div_top.sv ====
`timescale 1ns/10ps

// request queue in front of the sequencer and the radix-4 datapath
module div_top
	import div_pkg::*;
#(
	parameter int QUEUE_DEPTH = 4
) (
	input logic clk,
	input logic rst,
	input logic push,
	input word_t dividend,
	input word_t divisor,
	input logic unsign,
	output logic full,
	output logic busy,
	output logic done,
	output word_t quot,
	output word_t remd
);

	logic d_init;
	logic e_advance;
	logic e_last;

	div_op_if op_bus ();

	div_request_queue #(
		.QUEUE_DEPTH (QUEUE_DEPTH)
	) u_queue (
		.clk      (clk),
		.rst      (rst),
		.push     (push),
		.dividend (dividend),
		.divisor  (divisor),
		.unsign   (unsign),
		.full     (full),
		.op       (op_bus.queue_mp)
	);

	div_sequencer u_seq (
		.clk       (clk),
		.rst       (rst),
		.op        (op_bus.seq_mp),
		.d_init    (d_init),
		.e_advance (e_advance),
		.e_last    (e_last),
		.busy      (busy),
		.done      (done)
	);

	// operands come straight from the queue head, loaded on d_init
	long_div u_div (
		.clk       (clk),
		.d_init    (d_init),
		.e_advance (e_advance),
		.e_last    (e_last),
		.dividend  (op_bus.dividend),
		.divisor   (op_bus.divisor),
		.unsign    (op_bus.unsign),
		.quot      (quot),
		.remd      (remd)
	);

endmodule

// ==== tb/tb_clk_gen.sv ====
`timescale 1ns/10ps

// free running testbench clock and a synchronous reset pulse
module tb_clk_gen #(
	parameter int HALF_PERIOD = 10,	// ns, 20 ns period
	parameter int RST_CYCLES = 4
) (
	output logic clk,
	output logic rst
);

	initial begin
		clk = 1'b0;
		forever #(HALF_PERIOD) clk = ~clk;
	end

	// release lines up with the stimulus delay after the edge
	initial begin
		rst = 1'b1;
		repeat (RST_CYCLES) @(posedge clk);
		#2 rst = 1'b0;
	end

endmodule

// ==== tb/tb_checker.sv ====
`timescale 1ns/10ps

// watches the DUT ports on the falling edge, where everything is settled
module tb_checker
	import div_pkg::*;
(
	input logic clk,
	input logic rst,
	input logic push,
	input word_t dividend,
	input word_t divisor,
	input logic unsign,
	input logic full,
	input logic busy,
	input logic done,
	input word_t quot,
	input word_t remd,
	output int err_cnt,
	output int accept_cnt,
	output int result_cnt
);

	localparam int REQ_CYCLES = DIV_STEPS + 3;	// init, steps, last, done

	word_t exp_quot [$];
	word_t exp_remd [$];
	logic busy_prev;
	logic done_prev;
	logic rst_prev;
	int busy_len;	// busy cycles of the request in flight

	// truncating division on magnitudes, remainder follows the dividend
	task automatic model_div(input word_t a, input word_t b, input logic u,
		output word_t q, output word_t r);
		logic neg_a;
		logic neg_b;
		word_t mag_a;
		word_t mag_b;
		word_t q_mag;
		word_t r_mag;
		neg_a = a[31] & ~u;
		neg_b = b[31] & ~u;
		mag_a = neg_a ? -a : a;
		mag_b = neg_b ? -b : b;
		q_mag = mag_a / mag_b;
		r_mag = mag_a - q_mag * mag_b;
		q = (neg_a ^ neg_b) ? -q_mag : q_mag;
		r = neg_a ? -r_mag : r_mag;
	endtask

	task automatic compare(input string name, input word_t exp, input word_t act);
		if (exp !== act) begin
			$display("FAIL %0t %s expected %h got %h", $time, name, exp, act);
			err_cnt++;
		end
	endtask

	initial begin
		err_cnt = 0;
		accept_cnt = 0;
		result_cnt = 0;
		busy_prev = 1'b0;
		done_prev = 1'b0;
		rst_prev = 1'b1;
		busy_len = 0;
	end

	always @(negedge clk) begin
		word_t q;
		word_t r;

		// levels during reset and the first cycle after it
		if (rst || rst_prev) begin
			compare("done", 32'(1'b0), 32'(done));
			compare("busy", 32'(1'b0), 32'(busy));
			compare("full", 32'(1'b0), 32'(full));
		end

		if (!rst) begin
			if (push && !full) begin	// accepted at the coming edge
				model_div(dividend, divisor, unsign, q, r);
				exp_quot.push_back(q);
				exp_remd.push_back(r);
				accept_cnt++;
			end

			// a request starts when busy rises or follows a done directly
			if (busy && (!busy_prev || done_prev))
				busy_len = 1;
			else if (busy)
				busy_len++;

			if (done) begin
				result_cnt++;
				if (busy_len != REQ_CYCLES) begin
					$display("ERROR %0t: done came after %0d busy cycles instead of %0d",
						$time, busy_len, REQ_CYCLES);
					err_cnt++;
				end
				if (exp_quot.size() == 0) begin
					$display("ERROR %0t: done pulse with no request outstanding", $time);
					err_cnt++;
				end else begin
					compare("quot", exp_quot.pop_front(), quot);
					compare("remd", exp_remd.pop_front(), remd);
				end
			end
		end

		busy_prev = rst ? 1'b0 : busy;
		done_prev = rst ? 1'b0 : done;
		rst_prev = rst;
	end

endmodule

// ==== tb/tb_top.sv ====
`timescale 1ns/10ps

module tb_top
	import div_pkg::*;
();

	localparam int QUEUE_DEPTH = 4;
	localparam int RST_CYCLES = 4;
	localparam int N_UNSIGNED = 40;
	localparam int N_SIGNED = 40;
	localparam int N_EDGE = 14;
	localparam int N_BURST = 24;
	localparam int TOTAL_REQS = N_UNSIGNED + N_SIGNED + N_EDGE + N_BURST + 1;
	localparam int LIMIT_CYCLES = RST_CYCLES + TOTAL_REQS * (DIV_STEPS + 3) + 400;

	logic clk;
	logic rst;
	logic push;
	word_t dividend;
	word_t divisor;
	logic unsign;
	logic full;
	logic busy;
	logic done;
	word_t quot;
	word_t remd;
	int err_cnt;
	int accept_cnt;
	int result_cnt;
	int local_err;	// failures found here rather than in the checker
	int err_mark;
	logic full_seen;

	tb_clk_gen #(.HALF_PERIOD(10), .RST_CYCLES(RST_CYCLES)) u_clk (.clk(clk), .rst(rst));

	div_top #(.QUEUE_DEPTH(QUEUE_DEPTH)) DUT (
		.clk(clk), .rst(rst), .push(push), .dividend(dividend), .divisor(divisor),
		.unsign(unsign), .full(full), .busy(busy), .done(done), .quot(quot), .remd(remd)
	);

	tb_checker u_chk (
		.clk(clk), .rst(rst), .push(push), .dividend(dividend), .divisor(divisor),
		.unsign(unsign), .full(full), .busy(busy), .done(done), .quot(quot), .remd(remd),
		.err_cnt(err_cnt), .accept_cnt(accept_cnt), .result_cnt(result_cnt)
	);

	// ####################################################################
	// stimulus helpers
	// ####################################################################

	// holds push high across calls, so pushes go out back to back
	task automatic push_req(input word_t a, input word_t b, input logic u);
		@(posedge clk);
		#2;
		while (full) begin
			full_seen = 1'b1;
			push = 1'b0;
			@(posedge clk);
			#2;
		end
		push = 1'b1;
		dividend = a;
		divisor = b;
		unsign = u;
	endtask

	// busy only drops once the sequencer is idle and the queue is empty
	task automatic drain_queue();
		@(posedge clk);
		#2 push = 1'b0;
		while (busy) begin
			@(posedge clk);
			#2;
		end
	endtask

	task automatic report_phase(input string name);
		$display("phase %s: %0d results so far, %0d errors", name, result_cnt,
			err_cnt + local_err - err_mark);
		err_mark = err_cnt + local_err;
	endtask

	task automatic unsigned_pair(output word_t a, output word_t b);
		int sh;
		a = $urandom;
		sh = $urandom % 32;
		b = $urandom >> sh;	// spread of divisor sizes
		if (b == 0)
			b = 1;
	endtask

	// magnitudes stay below 2^31, so the overflow case never comes up
	task automatic signed_pair(input int combo, output word_t a, output word_t b);
		word_t ma;
		word_t mb;
		int sh;
		ma = $urandom;
		sh = $urandom % 31;
		mb = $urandom >> sh;
		ma[31] = 1'b0;
		mb[31] = 1'b0;
		if (mb == 0)
			mb = 1;
		a = combo[0] ? -ma : ma;
		b = combo[1] ? -mb : mb;
	endtask

	task automatic edge_cases();
		push_req(32'd0, 32'd7, 1'b1);
		push_req(32'd0, -32'd5, 1'b0);
		push_req(32'd123456, 32'd1, 1'b1);
		push_req(-32'd99, 32'd1, 1'b0);
		push_req(32'd5, 32'd9, 1'b1);
		push_req(-32'd5, 32'd9, 1'b0);
		push_req(32'd5, -32'd9, 1'b0);
		push_req(32'd42000, 32'd1000, 1'b1);
		push_req(-32'd42000, 32'd1000, 1'b0);	// negative exact multiples
		push_req(-32'd42000, -32'd1000, 1'b0);
		push_req(32'd42000, -32'd1000, 1'b0);
		push_req(32'h8000_0000, 32'd2, 1'b0);
		push_req(32'hffff_ffff, 32'hffff_ffff, 1'b1);
		push_req(-32'd7, -32'd7, 1'b0);
	endtask

	// ####################################################################
	// test sequence
	// ####################################################################

	initial begin
		word_t a;
		word_t b;
		push = 1'b0;
		dividend = '0;
		divisor = '0;
		unsign = 1'b0;
		local_err = 0;
		err_mark = 0;
		full_seen = 1'b0;
		void'($urandom(32'hddb3));

		wait (!rst);
		repeat (2) @(posedge clk);
		report_phase("reset");

		for (int i = 0; i < N_UNSIGNED; i++) begin
			unsigned_pair(a, b);
			push_req(a, b, 1'b1);
		end
		drain_queue();
		report_phase("unsigned");

		for (int i = 0; i < N_SIGNED; i++) begin
			signed_pair(i % 4, a, b);
			push_req(a, b, 1'b0);
		end
		drain_queue();
		report_phase("signed");

		edge_cases();
		drain_queue();
		report_phase("edge");

		full_seen = 1'b0;
		for (int i = 0; i < N_BURST; i++) begin
			if (i % 2)
				signed_pair(i % 4, a, b);
			else
				unsigned_pair(a, b);
			push_req(a, b, ~i[0]);
		end
		drain_queue();
		if (!full_seen) begin
			$display("ERROR %0t: burst never filled the request queue", $time);
			local_err++;
		end
		report_phase("burst");

		// lone request from idle, the checker times it from busy to done
		unsigned_pair(a, b);
		push_req(a, b, 1'b1);
		drain_queue();
		report_phase("timing");

		if (result_cnt != accept_cnt) begin
			$display("ERROR %0t: %0d pushes accepted but %0d results returned",
				$time, accept_cnt, result_cnt);
			local_err++;
		end

		$display("summary: %0d accepted, %0d results, %0d errors", accept_cnt, result_cnt,
			err_cnt + local_err);
		if (err_cnt + local_err == 0) begin
			$display("*** PASSED ***");
		end else begin
			$display("*** FAILED ***");
		end
		$finish;
	end

	// watchdog, sized from the request count
	initial begin
		repeat (LIMIT_CYCLES) @(posedge clk);
		$display("ERROR %0t: run did not finish within %0d cycles", $time, LIMIT_CYCLES);
		$display("*** FAILED ***");
		$finish;
	end

endmodule

// ==== tb.f ====
hdl/div_pkg.sv
hdl/div_op_if.sv
hdl/csa35.sv
hdl/long_div.sv
hdl/div_request_queue.sv
hdl/div_sequencer.sv
hdl/div_top.sv
tb/tb_clk_gen.sv
tb/tb_checker.sv
tb/tb_top.sv
